/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int DATA_BITS       = 8;    // Data bits per frame
    localparam int DIV_BITS        = 16;   // Bit period divisor width
    localparam int DEFAULT_DIVISOR = 16;   // Clocks per bit after reset
    localparam int FIFO_DEPTH      = 4;    // Receive FIFO entries

    // Register word addresses
    typedef enum logic [1:0] {
        REG_DATA   = 2'd0,
        REG_STATUS = 2'd1,
        REG_CTRL   = 2'd2,
        REG_DIV    = 2'd3
    } reg_addr_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    // Wishbone master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        logic [7:0] dat;
    } wb_req_t;

    // Wishbone slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                parity_odd;   // 1 selects odd parity
        logic [DIV_BITS-1:0] divisor;      // Clocks per bit
    } line_cfg_t;

    typedef struct packed {
        logic       done;           // One-cycle pulse per frame
        logic       parity_error;
        logic       frame_error;
        logic [7:0] data;
    } rx_result_t;

    // Status register layout, rx_valid in bit 7
    typedef struct packed {
        logic       rx_valid;
        logic       rx_full;
        logic       tx_busy;
        logic       parity_error;   // Sticky
        logic       frame_error;    // Sticky
        logic       overrun;        // Sticky
        logic [1:0] reserved;
    } uart_status_t;

endpackage

`default_nettype wire

/* hw/rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
    input  wire        clk,
    input  wire        reset,
    input  wire        push,
    input  wire [7:0]  push_data,
    input  wire        pop,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       full,
    output logic       overrun
);

    localparam int PTR_BITS = $clog2(uart_pkg::FIFO_DEPTH);

    logic [7:0]          mem [uart_pkg::FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;      // One extra bit to reach full depth
    logic                do_push;
    logic                do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_BITS+1)'(uart_pkg::FIFO_DEPTH));
    assign do_push = push && !full;      // New byte dropped when full
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];        // Head of queue

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            overrun <= push && full;
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

/* hw/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire uart_pkg::wb_req_t wb_req,
    output uart_pkg::wb_rsp_t      wb_rsp,
    input  wire                    rx,
    output logic                   tx
);

    uart_pkg::line_cfg_t  line_cfg;    // Shared by both directions
    uart_pkg::rx_result_t rx_result;
    logic                 tx_start;
    logic [7:0]           tx_data;
    logic                 tx_busy;
    logic                 fifo_push;
    logic [7:0]           fifo_rd_data;
    logic                 fifo_empty;
    logic                 fifo_full;
    logic                 fifo_overrun;
    logic                 fifo_pop;

    // Only clean frames reach the FIFO
    assign fifo_push = rx_result.done && !rx_result.parity_error && !rx_result.frame_error;

    uart_wb_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .line_cfg     (line_cfg),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .tx_busy      (tx_busy),
        .rx_result    (rx_result),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_full    (fifo_full),
        .fifo_overrun (fifo_overrun),
        .fifo_pop     (fifo_pop)
    );

    rx_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_data (rx_result.data),
        .pop       (fifo_pop),
        .rd_data   (fifo_rd_data),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .overrun   (fifo_overrun)
    );

    uart_rx u_rx (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .line_cfg  (line_cfg),
        .rx_result (rx_result)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .line_cfg (line_cfg),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* hw/uart_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_wb_regs (
    input  wire                        clk,
    input  wire                        reset,
    input  wire uart_pkg::wb_req_t     wb_req,
    output uart_pkg::wb_rsp_t          wb_rsp,
    output uart_pkg::line_cfg_t        line_cfg,
    output logic                       tx_start,
    output logic [7:0]                 tx_data,
    input  wire                        tx_busy,
    input  wire uart_pkg::rx_result_t  rx_result,
    input  wire [7:0]                  fifo_rd_data,
    input  wire                        fifo_empty,
    input  wire                        fifo_full,
    input  wire                        fifo_overrun,
    output logic                       fifo_pop
);

    logic                   accept;          // Request taken this cycle
    logic                   ack;             // Single-cycle bus ack
    logic [7:0]             rdata;           // Read data for the bus
    logic                   wait_low;        // Blocks a second ack until stb drops
    logic                   parity_odd;
    logic [7:0]             div_lo;          // Divisor bits 11:4
    logic                   parity_error;
    logic                   frame_error;
    logic                   overrun;
    uart_pkg::uart_status_t status;
    uart_pkg::uart_status_t clr;             // Write-one-to-clear mask

    assign accept = wb_req.cyc && wb_req.stb && !ack && !wait_low;
    assign clr    = (accept && wb_req.we && wb_req.adr == uart_pkg::REG_STATUS)
                    ? uart_pkg::uart_status_t'(wb_req.dat) : '0;

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdata;

    assign status.rx_valid     = !fifo_empty;
    assign status.rx_full      = fifo_full;
    assign status.tx_busy      = tx_busy;
    assign status.parity_error = parity_error;
    assign status.frame_error  = frame_error;
    assign status.overrun      = overrun;
    assign status.reserved     = 2'b00;

    assign line_cfg.parity_odd = parity_odd;
    assign line_cfg.divisor    = {{(uart_pkg::DIV_BITS-12){1'b0}}, div_lo, 4'b0000};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ack          <= 1'b0;
            wait_low     <= 1'b0;
            tx_start     <= 1'b0;
            fifo_pop     <= 1'b0;
            parity_odd   <= 1'b0;
            div_lo       <= 8'(uart_pkg::DEFAULT_DIVISOR >> 4);
            parity_error <= 1'b0;
            frame_error  <= 1'b0;
            overrun      <= 1'b0;
        end
        else
        begin
            ack <= accept;
            if (ack)
                wait_low <= 1'b1;
            else if (!wb_req.stb)
                wait_low <= 1'b0;
            // Writes to DATA while the transmitter is busy are lost
            tx_start <= accept && wb_req.we && wb_req.adr == uart_pkg::REG_DATA && !tx_busy;
            fifo_pop <= accept && !wb_req.we && wb_req.adr == uart_pkg::REG_DATA && !fifo_empty;
            if (accept && wb_req.we && wb_req.adr == uart_pkg::REG_CTRL)
                parity_odd <= wb_req.dat[0];
            if (accept && wb_req.we && wb_req.adr == uart_pkg::REG_DIV)
                div_lo <= (wb_req.dat == 8'd0) ? 8'd1 : wb_req.dat;   // Floor at 16 clocks
            // Set wins over a clear in the same cycle
            parity_error <= (parity_error && !clr.parity_error)
                            || (rx_result.done && rx_result.parity_error);
            frame_error  <= (frame_error && !clr.frame_error)
                            || (rx_result.done && rx_result.frame_error);
            overrun      <= (overrun && !clr.overrun) || fifo_overrun;
        end
    end

    // Read data mux and transmit byte
    always_ff @(posedge clk)
    begin
        if (accept && wb_req.we && wb_req.adr == uart_pkg::REG_DATA)
            tx_data <= wb_req.dat;
        if (accept)
        begin
            case (wb_req.adr)
                uart_pkg::REG_DATA:   rdata <= fifo_empty ? 8'd0 : fifo_rd_data;
                uart_pkg::REG_STATUS: rdata <= status;
                uart_pkg::REG_CTRL:   rdata <= {7'd0, parity_odd};
                default:              rdata <= div_lo;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb.f */
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hw/rx_fifo.sv
hw/uart_wb_regs.sv
hw/uart_top.sv
testbench/uart_props.sv
testbench/tb_uart.sv

/* testbench/tb_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

    localparam int CLK_PERIOD = 20;
    localparam int ACK_LIMIT  = 16;                      // Cycles allowed for an ack
    localparam int FRAME_CLOCKS = 11 * (8 * 16 + 15 * 32);   // 8 frames at 16, 15 at 32

    logic              clk;
    logic              reset;
    uart_pkg::wb_req_t wb_req;
    uart_pkg::wb_rsp_t wb_rsp;
    logic              tx_line;
    logic              rx_line;
    logic              model_rx;          // Line driven by send_frame
    logic              use_model;         // 1 breaks the loopback
    logic [31:0]       seed;
    int                cur_div;           // Clocks per bit in the DUT
    logic              cur_odd;
    logic [8:0]        exp_tx[$];         // {parity_odd, data} per written byte
    int                errors;
    int                tests;
    int                failed_tests;
    int                test_errors_base;

    assign rx_line = use_model ? model_rx : tx_line;   // Loopback mux

    uart_top dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .rx     (rx_line),
        .tx     (tx_line)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Parity bit that makes the count of ones even, or odd in odd mode
    function automatic logic parity_ref(input logic [7:0] data, input logic odd);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++)
            ones += int'(data[i]);
        return odd ? (ones % 2 == 0) : (ones % 2 == 1);
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #2;                                // Drive point after the edge
    endtask

    task automatic skip_falls(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic mismatch(input string msg, input logic [7:0] got, input logic [7:0] exp);
        $display("CHECK FAILED at %0t: %s, got %02h expected %02h", $time, msg, got, exp);
        errors++;
    endtask

    // Request held through the edge where ack is seen
    task automatic bus_cycle(input logic we, input uart_pkg::reg_addr_t adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int n;
        n = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do
        begin
            wait_clocks(1);
            n++;
        end
        while (!wb_rsp.ack && n < ACK_LIMIT);
        if (!wb_rsp.ack)
        begin
            $display("Wishbone error: no ack for the access to address %0d", adr);
            errors++;
        end
        else if (n != 1)
        begin
            $display("Wishbone error: ack came %0d cycles after the request, not 1", n);
            errors++;
        end
        rdat = wb_rsp.dat;                 // Valid while ack is high
        wait_clocks(1);
        wb_req = '0;
        wait_clocks(1);                    // stb low for a full cycle
    endtask

    task automatic wb_write(input uart_pkg::reg_addr_t adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input uart_pkg::reg_addr_t adr, output logic [7:0] dat);
        bus_cycle(1'b0, adr, 8'h00, dat);
    endtask

    task automatic wait_status(input int bit_idx, input logic value);
        logic [7:0] st;
        int         polls;
        polls = 0;
        wb_read(uart_pkg::REG_STATUS, st);
        while (st[bit_idx] !== value && polls < 11 * cur_div)
        begin
            wb_read(uart_pkg::REG_STATUS, st);
            polls++;
        end
        if (st[bit_idx] !== value)
        begin
            $display("Status bit %0d never reached %0b while polling", bit_idx, value);
            errors++;
        end
    endtask

    task automatic loopback_byte(input logic [7:0] data);
        logic [7:0] got;
        wait_status(5, 1'b0);              // tx_busy
        exp_tx.push_back({cur_odd, data});
        wb_write(uart_pkg::REG_DATA, data);
        wait_status(7, 1'b1);              // rx_valid
        wb_read(uart_pkg::REG_DATA, got);
        if (got !== data)
            mismatch("loopback byte from DATA", got, data);
    endtask

    // Start, 8 data LSB first, parity, stop, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                              input logic low_stop);
        logic [10:0] bits;
        bits = {!low_stop, parity_ref(data, cur_odd) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            model_rx = bits[i];
            wait_clocks(cur_div);
        end
        model_rx = 1'b1;
        wait_clocks(cur_div);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors_base)
            $display("test %0d %s: ok", tests, name);
        else
        begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors_base);
            failed_tests++;
        end
        test_errors_base = errors;
    endtask

    // Frame compare, mid-bit samples on the falling clock
    initial
    begin : frame_check
        logic [10:0] frame;
        logic [8:0]  exp_word;
        int          div;
        forever
        begin
            @(negedge tx_line);
            div = cur_div;
            skip_falls(div / 2);
            for (int i = 0; i < 11; i++)
            begin
                frame[i] = tx_line;
                if (i < 10)
                    skip_falls(div);
            end
            if (exp_tx.size() == 0)
            begin
                $display("A frame appeared on tx with no byte written");
                errors++;
            end
            else
            begin
                exp_word = exp_tx.pop_front();
                if (frame[8:1] !== exp_word[7:0])
                    mismatch("tx frame data", frame[8:1], exp_word[7:0]);
                if (frame[9] !== parity_ref(exp_word[7:0], exp_word[8]))
                    mismatch("tx parity bit", frame[9], parity_ref(exp_word[7:0], exp_word[8]));
                if (frame[0] !== 1'b0 || frame[10] !== 1'b1)
                    mismatch("tx start and stop bits", {frame[10], frame[0]}, 8'h02);
            end
        end
    end

    initial
    begin
        #(2 * FRAME_CLOCKS * CLK_PERIOD);
        $display("Timeout: the run went past twice the total frame time of the tests");
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin : main
        logic [7:0] got;
        logic [7:0] sent [5];
        clk              = 1'b0;
        reset            = 1'b1;
        wb_req           = '0;
        model_rx         = 1'b1;
        use_model        = 1'b0;
        seed             = 32'hdf54;
        cur_div          = uart_pkg::DEFAULT_DIVISOR;
        cur_odd          = 1'b0;
        errors           = 0;
        tests            = 0;
        failed_tests     = 0;
        test_errors_base = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        wait_clocks(1);

        wb_read(uart_pkg::REG_STATUS, got);
        if (got !== 8'h00)
            mismatch("STATUS after reset", got, 8'h00);
        wb_read(uart_pkg::REG_CTRL, got);
        if (got !== 8'h00)
            mismatch("CTRL after reset", got, 8'h00);
        wb_read(uart_pkg::REG_DIV, got);
        if (got !== 8'(uart_pkg::DEFAULT_DIVISOR >> 4))
            mismatch("DIV after reset", got, 8'(uart_pkg::DEFAULT_DIVISOR >> 4));
        if (tx_line !== 1'b1)
            mismatch("tx idle level after reset", tx_line, 8'h01);
        end_test("reset values");

        for (int i = 0; i < 8; i++)
        begin
            seed = lcg_next(seed);
            loopback_byte(seed[23:16]);
        end
        end_test("even parity loopback");

        wb_write(uart_pkg::REG_CTRL, 8'h01);
        cur_odd = 1'b1;
        wb_write(uart_pkg::REG_DIV, 8'h02);
        cur_div = 2 * 16;                  // DIV counts in steps of 16 clocks
        wb_read(uart_pkg::REG_CTRL, got);
        if (got !== 8'h01)
            mismatch("CTRL readback", got, 8'h01);
        wb_read(uart_pkg::REG_DIV, got);
        if (got !== 8'h02)
            mismatch("DIV readback", got, 8'h02);
        for (int i = 0; i < 8; i++)
        begin
            seed = lcg_next(seed);
            loopback_byte(seed[23:16]);
        end
        end_test("odd parity at divisor 32");

        wait_status(5, 1'b0);              // Line idle before the switch
        use_model = 1'b1;
        seed = lcg_next(seed);
        send_frame(seed[23:16], 1'b1, 1'b0);
        seed = lcg_next(seed);
        send_frame(seed[23:16], 1'b0, 1'b1);
        wb_read(uart_pkg::REG_STATUS, got);
        if (got !== 8'h18)                 // parity_error and frame_error only
            mismatch("STATUS after bad frames", got, 8'h18);
        wb_write(uart_pkg::REG_STATUS, 8'hff);
        wb_read(uart_pkg::REG_STATUS, got);
        if (got !== 8'h00)
            mismatch("STATUS after clear", got, 8'h00);
        end_test("parity and framing errors");

        for (int i = 0; i < 5; i++)
        begin
            seed = lcg_next(seed);
            sent[i] = seed[23:16];
            send_frame(sent[i], 1'b0, 1'b0);
        end
        wb_read(uart_pkg::REG_STATUS, got);
        if (got !== 8'hc4)                 // rx_valid, rx_full, overrun
            mismatch("STATUS after five bytes", got, 8'hc4);
        for (int i = 0; i < 4; i++)
        begin
            wb_read(uart_pkg::REG_DATA, got);
            if (got !== sent[i])
                mismatch("FIFO byte order", got, sent[i]);
        end
        wb_read(uart_pkg::REG_STATUS, got);
        if (got[7] !== 1'b0)
            mismatch("rx_valid after draining", got[7], 8'h00);
        wb_read(uart_pkg::REG_DATA, got);
        if (got !== 8'h00)
            mismatch("DATA read with empty FIFO", got, 8'h00);
        end_test("overrun");

        if (exp_tx.size() != 0)
        begin
            $display("%0d written bytes never appeared on tx", exp_tx.size());
            errors++;
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/uart_props.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_props (
    input wire                    clk,
    input wire                    reset,
    input wire uart_pkg::wb_req_t wb_req,
    input wire uart_pkg::wb_rsp_t wb_rsp,
    input wire                    tx,
    input wire                    tx_busy
);

    // Ack only answers a live request
    ack_with_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack high without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high for two cycles");

    // Master side, request held until ack
    request_stable: assert property (@(posedge clk) disable iff (reset)
        (wb_req.stb && !wb_rsp.ack)
        |=> ($stable(wb_req.we) && $stable(wb_req.adr) && $stable(wb_req.dat)))
        else $error("Wishbone request changed before ack");

    tx_idle_high: assert property (@(posedge clk) disable iff (reset)
        !tx_busy |-> tx)
        else $error("tx low while the transmitter is idle");

endmodule

bind uart_top uart_props u_props (
    .clk     (clk),
    .reset   (reset),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .tx      (tx),
    .tx_busy (tx_busy)
);

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    rx,
    input  wire uart_pkg::line_cfg_t line_cfg,
    output uart_pkg::rx_result_t   rx_result
);

    logic                          rx_meta;       // First synchronizer stage
    logic                          rx_sync;       // Synchronized line
    logic                          rx_prev;       // For falling edge detect
    uart_pkg::rx_state_t           state;
    logic [uart_pkg::DIV_BITS-1:0] clk_cnt;
    logic [3:0]                    bit_cnt;
    logic [7:0]                    shift;         // LSB arrives first
    logic                          parity_bit;
    logic                          done;
    logic                          parity_error;
    logic                          frame_error;
    logic                          at_half;
    logic                          at_full;

    assign at_half = (clk_cnt == (line_cfg.divisor >> 1) - 1'b1);   // Middle of start bit
    assign at_full = (clk_cnt == line_cfg.divisor - 1'b1);          // Middle of next bit

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;   // Line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= uart_pkg::RX_IDLE;
            clk_cnt      <= '0;
            bit_cnt      <= '0;
            done         <= 1'b0;
            parity_error <= 1'b0;
            frame_error  <= 1'b0;
        end
        else
        begin
            done    <= 1'b0;                // Pulse only
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync)   // Start edge
                        state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START:
                    if (at_half)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        // Line back high means a glitch, not a start bit
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                uart_pkg::RX_DATA:
                    if (at_full)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'(uart_pkg::DATA_BITS - 1))
                            state <= uart_pkg::RX_PARITY;
                    end
                uart_pkg::RX_PARITY:
                    if (at_full)
                    begin
                        clk_cnt <= '0;
                        state   <= uart_pkg::RX_STOP;
                    end
                uart_pkg::RX_STOP:
                    if (at_full)
                    begin
                        done         <= 1'b1;
                        // Data plus parity must XOR to the selected mode
                        parity_error <= ((^shift) ^ parity_bit) != line_cfg.parity_odd;
                        frame_error  <= !rx_sync;   // Stop bit must be high
                        state        <= uart_pkg::RX_IDLE;
                    end
                default:
                    state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (at_full && state == uart_pkg::RX_DATA)
            shift <= {rx_sync, shift[7:1]};   // Shift in from the top
        if (at_full && state == uart_pkg::RX_PARITY)
            parity_bit <= rx_sync;
    end

    assign rx_result.done         = done;
    assign rx_result.parity_error = parity_error;
    assign rx_result.frame_error  = frame_error;
    assign rx_result.data         = shift;

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      tx_start,
    input  wire [7:0]                tx_data,
    input  wire uart_pkg::line_cfg_t line_cfg,
    output logic                     tx,
    output logic                     tx_busy
);

    uart_pkg::tx_state_t           state;
    uart_pkg::line_cfg_t           cfg_q;      // Frozen for the whole frame
    logic [uart_pkg::DIV_BITS-1:0] clk_cnt;
    logic [3:0]                    bit_cnt;
    logic [7:0]                    shift;
    logic                          parity_bit;
    logic                          bit_end;

    assign bit_end = (clk_cnt == cfg_q.divisor - 1'b1);
    assign tx_busy = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= uart_pkg::TX_IDLE;
            tx      <= 1'b1;                // Idle line
            clk_cnt <= '0;
            bit_cnt <= '0;
            cfg_q   <= '{parity_odd: 1'b0, divisor: uart_pkg::DIV_BITS'(uart_pkg::DEFAULT_DIVISOR)};
        end
        else
        begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE:
                begin
                    clk_cnt <= '0;
                    if (tx_start)
                    begin
                        cfg_q   <= line_cfg;
                        bit_cnt <= '0;
                        tx      <= 1'b0;    // Start bit
                        state   <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START:
                    if (bit_end)
                    begin
                        tx    <= shift[0];
                        state <= uart_pkg::TX_DATA;
                    end
                uart_pkg::TX_DATA:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'(uart_pkg::DATA_BITS - 1))
                        begin
                            tx    <= parity_bit;
                            state <= uart_pkg::TX_PARITY;
                        end
                        else
                            tx <= shift[1];     // Next bit before the shift lands
                    end
                uart_pkg::TX_PARITY:
                    if (bit_end)
                    begin
                        tx    <= 1'b1;          // Stop bit
                        state <= uart_pkg::TX_STOP;
                    end
                uart_pkg::TX_STOP:
                    if (bit_end)
                        state <= uart_pkg::TX_IDLE;
                default:
                    state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Payload, loaded on start and shifted per data bit
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::TX_IDLE && tx_start)
        begin
            shift      <= tx_data;
            parity_bit <= (^tx_data) ^ line_cfg.parity_odd;
        end
        else if (state == uart_pkg::TX_DATA && bit_end)
            shift <= shift >> 1;
    end

endmodule

`default_nettype wire
